// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the USB transmitter testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module usb_tx_tb \
  -f usb_tx.f -Mdir obj_dir -o usb_tx_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/usb_tx_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "^>>> PASS$" sim.log; then
  exit 0
fi
exit 1

// ==== sim/usb_tx_sva.sv ====
/*
 * Bound assertions for the USB transmitter top level
 * APB ready rule and legal line states
 */
module usb_tx_sva (
  input logic clk_i,
  input logic rst_ni,
  input logic pready_i,
  input logic pinflip_i,
  input logic usb_dp_i,
  input logic usb_dn_i,
  input logic usb_oe_i
);
  timeunit 1ns;
  timeprecision 100ps;

  // APB slave never inserts wait states
  assert property (@(posedge clk_i) disable iff (!rst_ni) pready_i)
    else $error("pready low");

  // Idle line is J, the line register sees pin flip one cycle late
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    !usb_oe_i |-> ({usb_dp_i, usb_dn_i} == ($past(pinflip_i) ? 2'b01 : 2'b10)))
    else $error("line not in J while the driver is off");

  // SE1 never appears
  assert property (@(posedge clk_i) disable iff (!rst_ni) !(usb_dp_i && usb_dn_i))
    else $error("D+ and D- both high");

endmodule

bind usb_tx_top usb_tx_sva i_sva (
  .clk_i, .rst_ni,
  .pready_i  (pready_o),
  .pinflip_i (pinflip),
  .usb_dp_i  (usb_dp_o),
  .usb_dn_i  (usb_dn_o),
  .usb_oe_i  (usb_oe_o)
);

// ==== sim/usb_tx_tb.sv ====
/*
 * Testbench for the USB full-speed transmitter
 * APB driver, NRZI line decoder and a table of packets with checks
 */
module usb_tx_tb;
  timeunit 1ns;
  timeprecision 100ps;
  import usb_tx_pkg::*;

  localparam int          FifoDepth = FifoDepthDefault;
  localparam int          ClkPerBit = ClkPerBitDefault;
  localparam int          NumRows   = 7;
  localparam int          MarginCyc = 1500;
  localparam logic [31:0] Seed      = 32'h2321;

  typedef struct packed {
    logic [3:0]  pid;
    logic [31:0] nbytes;
    logic [31:0] seed_off;
    logic        flip;
    logic        all_ff;
  } row_t;

  // Handshakes, data packets of several sizes, a full FIFO, all ones and pin flip
  localparam row_t Rows [NumRows] = '{
    '{PidAck,   32'd0,            32'd0,  1'b0, 1'b0},
    '{PidNak,   32'd0,            32'd0,  1'b1, 1'b0},
    '{PidData0, 32'd5,            32'd1,  1'b0, 1'b0},
    '{PidData1, 32'(FifoDepth),   32'd7,  1'b0, 1'b0},
    '{PidData0, 32'd8,            32'd0,  1'b0, 1'b1},
    '{PidData1, 32'd3,            32'd13, 1'b1, 1'b0},
    '{PidData1, 32'd0,            32'd0,  1'b0, 1'b0}
  };

  logic        clk_i, rst_ni;
  logic [7:0]  paddr_i;
  logic        psel_i, penable_i, pwrite_i;
  logic [31:0] pwdata_i, prdata_o;
  logic        pready_o, pslverr_o;
  logic        usb_dp_o, usb_dn_o, usb_oe_o;
  int          value_errs, other_errs;
  logic [7:0]  exp_q[$];
  logic [7:0]  rx_q[$];

  usb_tx_top i_dut (.*);

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // Reflected form of 0x8005 since bytes enter low bit first
  function automatic logic [15:0] crc16_update(input logic [15:0] crc, input logic [7:0] b);
    crc = crc ^ {8'h00, b};
    for (int k = 0; k < 8; k++) begin
      crc = crc[0] ? ((crc >> 1) ^ 16'hA001) : (crc >> 1);
    end
    return crc;
  endfunction

  // Twice the SYNC, PID, payload, CRC and EOP bits of every row
  function automatic int timeout_cycles();
    int bits;
    bits = 0;
    for (int r = 0; r < NumRows; r++) begin
      bits += (Rows[r].nbytes + 5) * 8;
    end
    return bits * ClkPerBit * 2 + MarginCyc;
  endfunction

  task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else begin
      value_errs++;
      $display("CHECK FAILED t=%0t %s expected=%0h actual=%0h", $time, name, exp, got);
    end
  endtask

  task automatic apb_xfer(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
                          output logic [31:0] rdata, output logic err);
    @(posedge clk_i);
    #0.5;
    psel_i    = 1'b1;
    penable_i = 1'b0;
    pwrite_i  = wr;
    paddr_i   = addr;
    pwdata_i  = wdata;
    @(posedge clk_i);
    #0.5;
    penable_i = 1'b1;
    // Response is stable in the middle of the access phase
    @(negedge clk_i);
    rdata = prdata_o;
    err   = pslverr_o;
    @(posedge clk_i);
    #0.5;
    psel_i    = 1'b0;
    penable_i = 1'b0;
  endtask

  //////////////////////////////
  // Line decoder
  //////////////////////////////
  task automatic decode_packet(input logic flip);
    logic [1:0] jstate;
    logic       prev, level, b, se0_ok, j_ok;
    int         ones, nbits;
    logic [7:0] cur;
    jstate = flip ? 2'b01 : 2'b10;
    prev   = 1'b1;
    ones   = 0;
    nbits  = 0;
    cur    = '0;
    rx_q.delete();
    // Wait for the first K of SYNC and move to the middle of the bit
    do begin
      @(negedge clk_i);
    end while ({usb_dp_o, usb_dn_o} == jstate);
    repeat (ClkPerBit / 2 - 1) @(negedge clk_i);
    while ({usb_dp_o, usb_dn_o} != 2'b00) begin
      check_eq("usb_oe_o packet", 32'(usb_oe_o), 32'd1);
      level = flip ? usb_dn_o : usb_dp_o;
      b     = (level == prev);
      prev  = level;
      if (ones == 6) begin
        assert (b == 1'b0) else begin
          other_errs++;
          $display("ERROR t=%0t: no zero inserted after six ones", $time);
        end
        ones = 0;
      end else begin
        cur   = {b, cur[7:1]};
        nbits = nbits + 1;
        ones  = b ? ones + 1 : 0;
        if (nbits == 8) begin
          rx_q.push_back(cur);
          nbits = 0;
        end
      end
      repeat (ClkPerBit) @(negedge clk_i);
    end
    repeat (ClkPerBit) @(negedge clk_i);
    se0_ok = ({usb_dp_o, usb_dn_o} == 2'b00);
    repeat (ClkPerBit) @(negedge clk_i);
    j_ok   = ({usb_dp_o, usb_dn_o} == jstate);
    assert (se0_ok && j_ok && nbits == 0) else begin
      other_errs++;
      $display("ERROR t=%0t: packet did not end with SE0 SE0 J on a byte boundary", $time);
    end
  endtask

  //////////////////////////////
  // Stimulus and checks
  //////////////////////////////
  initial begin
    logic [31:0] rdata, rng;
    logic        err;
    logic [15:0] crc;
    logic [7:0]  b;
    int          n, polls;
    rst_ni     = 1'b0;
    paddr_i    = '0;
    psel_i     = 1'b0;
    penable_i  = 1'b0;
    pwrite_i   = 1'b0;
    pwdata_i   = '0;
    value_errs = 0;
    other_errs = 0;
    repeat (3) @(posedge clk_i);
    #0.5;
    rst_ni = 1'b1;

    apb_xfer(1'b0, 8'h10, '0, rdata, err);
    check_eq("prdata_o unmapped", rdata, 32'd0);
    check_eq("pslverr_o unmapped", 32'(err), 32'd1);

    for (int r = 0; r < NumRows; r++) begin
      apb_xfer(1'b1, AddrCfg, {31'b0, Rows[r].flip}, rdata, err);
      apb_xfer(1'b0, AddrCfg, '0, rdata, err);
      check_eq("prdata_o cfg", rdata, {31'b0, Rows[r].flip});
      @(negedge clk_i);
      // J is D+ high, or D- high with pin flip
      check_eq("idle {dp,dn}", 32'({usb_dp_o, usb_dn_o}), Rows[r].flip ? 32'd1 : 32'd2);
      check_eq("usb_oe_o idle", 32'(usb_oe_o), 32'd0);

      exp_q.delete();
      exp_q.push_back(8'h80);
      exp_q.push_back({~Rows[r].pid, Rows[r].pid});
      rng = Seed + Rows[r].seed_off;
      crc = Crc16Init;
      n   = int'(Rows[r].nbytes);
      for (int i = 0; i < n; i++) begin
        rng = xorshift32(rng);
        b   = Rows[r].all_ff ? 8'hFF : rng[7:0];
        crc = crc16_update(crc, b);
        exp_q.push_back(b);
        apb_xfer(1'b1, AddrData, {24'b0, b}, rdata, err);
        check_eq("pslverr_o push", 32'(err), 32'd0);
      end
      if (n == FifoDepth) begin
        apb_xfer(1'b1, AddrData, 32'h5A, rdata, err);
        check_eq("pslverr_o push full", 32'(err), 32'd1);
      end
      apb_xfer(1'b0, AddrStatus, '0, rdata, err);
      check_eq("status count", 32'(rdata[12:8]), n);
      check_eq("status full", 32'(rdata[2]), (n == FifoDepth) ? 32'd1 : 32'd0);
      if (Rows[r].pid[1:0] == 2'b11) begin
        exp_q.push_back(~crc[7:0]);
        exp_q.push_back(~crc[15:8]);
      end

      apb_xfer(1'b1, AddrCtrl, {23'b0, 1'b1, 4'b0, Rows[r].pid}, rdata, err);
      check_eq("pslverr_o start", 32'(err), 32'd0);
      apb_xfer(1'b1, AddrCtrl, {23'b0, 1'b1, 4'b0, Rows[r].pid}, rdata, err);
      check_eq("pslverr_o start busy", 32'(err), 32'd1);
      decode_packet(Rows[r].flip);

      check_eq("packet length", 32'(rx_q.size()), 32'(exp_q.size()));
      for (int i = 0; i < exp_q.size() && i < rx_q.size(); i++) begin
        check_eq($sformatf("packet byte %0d", i), 32'(rx_q[i]), 32'(exp_q[i]));
      end

      apb_xfer(1'b0, AddrStatus, '0, rdata, err);
      check_eq("status done", 32'(rdata[1]), 32'd1);
      polls = 0;
      do begin
        apb_xfer(1'b0, AddrStatus, '0, rdata, err);
        if (polls == 0) begin
          check_eq("status done cleared", 32'(rdata[1]), 32'd0);
        end
        polls++;
      end while (rdata[0] && polls < 20);
      assert (!rdata[0]) else begin
        other_errs++;
        $display("ERROR t=%0t: transmitter stayed busy after the packet", $time);
      end
    end

    $display("Errors: %0d value, %0d protocol", value_errs, other_errs);
    if (value_errs + other_errs == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

  initial begin
    repeat (timeout_cycles()) @(posedge clk_i);
    $display("Watchdog expired after %0d cycles, the run did not complete", timeout_cycles());
    $display(">>> FAIL");
    $finish;
  end

endmodule

// ==== src/usb_fs_tx.sv ====
/*
 * USB full-speed packet serializer
 * SYNC, PID, payload and CRC16 with bit stuffing, NRZI coding and EOP
 */
module usb_fs_tx #(
  parameter int ClkPerBit = usb_tx_pkg::ClkPerBitDefault
) (
  input  logic          clk_i,
  input  logic          rst_ni,
  input  logic          pkt_start_i,
  input  logic [3:0]    pid_i,
  input  logic          pinflip_i,
  usb_tx_fifo_if.reader fifo_rd,
  output logic          busy_o,
  output logic          pkt_end_o,
  output logic          usb_dp_o,
  output logic          usb_dn_o,
  output logic          usb_oe_o
);
  import usb_tx_pkg::*;

  localparam int StrobeW = $clog2(ClkPerBit);

  typedef enum logic [2:0] {Idle, Sync, Pid, DataOrCrc, CrcHigh, Eop} pkt_state_e;
  typedef enum logic [1:0] {OutIdle, OutWait, OutSend} out_state_e;

  logic [StrobeW-1:0] strobe_cnt_q;
  logic               bit_strobe;
  pkt_state_e         state_q, state_d;
  out_state_e         out_q, out_d;
  logic [3:0]         pid_q;
  logic               is_data_pid;
  logic [7:0]         data_sr_q, data_sr_d;
  logic [7:0]         oe_sr_q, oe_sr_d;
  logic [7:0]         se0_sr_q, se0_sr_d;
  logic [4:0]         hist_q, hist_d;
  logic [2:0]         bit_cnt_q, bit_cnt_d;
  logic               byte_strobe_q, byte_strobe_d;
  logic               payload_q, payload_d;
  logic               stuffed_q;
  logic [15:0]        crc_q, crc_d, crc_rev;
  logic               tx_bit, tx_oe, tx_se0, stuff;
  logic               nrzi_en;
  logic               oe_q, oe_d, nrzi_q, nrzi_d, se0_q, se0_d;
  logic [2:0]         eop_q, eop_d;
  logic [1:0]         line_raw, line_d;

  // One bit strobe every ClkPerBit cycles
  assign bit_strobe = (strobe_cnt_q == StrobeW'(ClkPerBit - 1));

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      strobe_cnt_q <= '0;
    end else begin
      strobe_cnt_q <= bit_strobe ? '0 : strobe_cnt_q + 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (pkt_start_i) pid_q <= pid_i;
  end

  // Data PIDs share the low bits 11
  assign is_data_pid = (pid_q[1:0] == PidData0[1:0]);

  assign tx_bit  = data_sr_q[0];
  assign tx_oe   = oe_sr_q[0];
  assign tx_se0  = se0_sr_q[0];
  // Sixth one in a row is on the line, a zero follows
  assign stuff   = tx_bit && (&hist_q);
  assign crc_rev = {<<{crc_q}};

  //////////////////////////////
  // Packet FSM
  //////////////////////////////
  always_comb begin
    state_d        = state_q;
    data_sr_d      = data_sr_q;
    oe_sr_d        = oe_sr_q;
    se0_sr_d       = se0_sr_q;
    payload_d      = payload_q;
    hist_d         = hist_q;
    bit_cnt_d      = bit_cnt_q;
    fifo_rd.pop_en = 1'b0;

    unique case (state_q)
      Idle: begin
        if (pkt_start_i) state_d = Sync;
      end
      Sync: begin
        if (byte_strobe_q) begin
          state_d   = Pid;
          data_sr_d = 8'h80;
          oe_sr_d   = 8'hFF;
          se0_sr_d  = 8'h00;
        end
      end
      Pid: begin
        if (byte_strobe_q) begin
          state_d   = is_data_pid ? DataOrCrc : Eop;
          data_sr_d = {~pid_q, pid_q};
          oe_sr_d   = 8'hFF;
          se0_sr_d  = 8'h00;
        end
      end
      DataOrCrc: begin
        if (byte_strobe_q) begin
          oe_sr_d  = 8'hFF;
          se0_sr_d = 8'h00;
          if (!fifo_rd.empty) begin
            payload_d      = 1'b1;
            data_sr_d      = fifo_rd.pop_data;
            fifo_rd.pop_en = 1'b1;
          end else begin
            // FIFO ran dry so the payload ends here
            state_d   = CrcHigh;
            payload_d = 1'b0;
            data_sr_d = ~crc_rev[7:0];
          end
        end
      end
      CrcHigh: begin
        if (byte_strobe_q) begin
          state_d   = Eop;
          data_sr_d = ~crc_rev[15:8];
          oe_sr_d   = 8'hFF;
          se0_sr_d  = 8'h00;
        end
      end
      Eop: begin
        if (byte_strobe_q) begin
          state_d  = Idle;
          oe_sr_d  = 8'h07;
          se0_sr_d = 8'h07;
        end
      end
      default: state_d = Idle;
    endcase

    // Counter starts at 7 so SYNC loads after two bit times
    if (pkt_start_i) begin
      bit_cnt_d = 3'd7;
      hist_d    = '0;
    end else if (bit_strobe) begin
      hist_d = {tx_bit, hist_q[4:1]};
      if (stuff) begin
        data_sr_d[0] = 1'b0;
      end else begin
        bit_cnt_d = bit_cnt_q + 3'd1;
        data_sr_d = data_sr_q >> 1;
        oe_sr_d   = oe_sr_q >> 1;
        se0_sr_d  = se0_sr_q >> 1;
      end
    end
  end

  assign byte_strobe_d = bit_strobe && !stuff && !pkt_start_i && (bit_cnt_q == 3'd0);

  // CRC skips the inserted zero
  always_comb begin
    crc_d = crc_q;
    if (pkt_start_i) begin
      crc_d = Crc16Init;
    end else if (bit_strobe && payload_q && !stuffed_q) begin
      crc_d = {crc_q[14:0], 1'b0} ^ ((tx_bit ^ crc_q[15]) ? Crc16Poly : 16'h0000);
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q       <= Idle;
      data_sr_q     <= '0;
      oe_sr_q       <= '0;
      se0_sr_q      <= '0;
      hist_q        <= '0;
      bit_cnt_q     <= '0;
      byte_strobe_q <= 1'b0;
      payload_q     <= 1'b0;
      stuffed_q     <= 1'b0;
      crc_q         <= '0;
    end else begin
      state_q       <= state_d;
      data_sr_q     <= data_sr_d;
      oe_sr_q       <= oe_sr_d;
      se0_sr_q      <= se0_sr_d;
      hist_q        <= hist_d;
      bit_cnt_q     <= bit_cnt_d;
      byte_strobe_q <= byte_strobe_d;
      payload_q     <= payload_d;
      crc_q         <= crc_d;
      if (pkt_start_i) begin
        stuffed_q <= 1'b0;
      end else if (bit_strobe) begin
        stuffed_q <= stuff;
      end
    end
  end

  //////////////////////////////
  // NRZI and line output
  //////////////////////////////
  always_comb begin
    out_d   = out_q;
    nrzi_en = 1'b0;
    unique case (out_q)
      OutIdle: if (pkt_start_i) out_d = OutWait;
      OutWait: if (byte_strobe_q) out_d = OutSend;
      OutSend: begin
        nrzi_en = 1'b1;
        if (bit_strobe && !tx_oe) out_d = OutIdle;
      end
      default: out_d = OutIdle;
    endcase
  end

  always_comb begin
    oe_d   = oe_q;
    nrzi_d = nrzi_q;
    se0_d  = se0_q;
    eop_d  = eop_q;
    if (pkt_start_i) begin
      // Line idles at J, so the first SYNC bit gives K
      nrzi_d = 1'b1;
      eop_d  = 3'b100;
    end else if (bit_strobe && nrzi_en) begin
      oe_d = tx_oe;
      if (tx_se0) begin
        // Two SE0 bits then J
        eop_d = eop_q >> 1;
        if (eop_q[0]) begin
          nrzi_d = 1'b1;
          se0_d  = 1'b0;
        end else begin
          se0_d = 1'b1;
        end
      end else if (!tx_bit) begin
        nrzi_d = ~nrzi_q;
      end
      if (!tx_oe) nrzi_d = 1'b1;
    end
  end

  assign line_raw = se0_d ? LineSe0 : (nrzi_d ? LineJ : LineK);
  assign line_d   = pinflip_i ? {line_raw[0], line_raw[1]} : line_raw;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      out_q                <= OutIdle;
      oe_q                 <= 1'b0;
      nrzi_q               <= 1'b1;
      se0_q                <= 1'b0;
      eop_q                <= '0;
      {usb_dp_o, usb_dn_o} <= LineJ;
    end else begin
      out_q                <= out_d;
      oe_q                 <= oe_d;
      nrzi_q               <= nrzi_d;
      se0_q                <= se0_d;
      eop_q                <= eop_d;
      {usb_dp_o, usb_dn_o} <= line_d;
    end
  end

  assign usb_oe_o  = oe_q;
  // Strobe of the closing J bit
  assign pkt_end_o = bit_strobe && (se0_sr_q[1:0] == 2'b01);
  assign busy_o    = (state_q != Idle) || (out_q != OutIdle);

endmodule

// ==== src/usb_tx_apb_regs.sv ====
/*
 * APB register block for the USB transmitter
 * Holds PID and pin flip, pushes payload bytes and starts packets
 */
module usb_tx_apb_regs #(
  parameter int FifoDepth = usb_tx_pkg::FifoDepthDefault
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic [7:0]           paddr_i,
  input  logic                 psel_i,
  input  logic                 penable_i,
  input  logic                 pwrite_i,
  input  logic [31:0]          pwdata_i,
  output logic [31:0]          prdata_o,
  output logic                 pready_o,
  output logic                 pslverr_o,
  usb_tx_fifo_if.writer        fifo_wr,
  input  logic                 busy_i,
  input  logic                 pkt_end_i,
  output logic                 pkt_start_o,
  output logic [3:0]           pid_o,
  output logic                 pinflip_o
);
  import usb_tx_pkg::*;

  localparam int CntW = $clog2(FifoDepth) + 1;

  logic        access, wr, mapped;
  logic        ctrl_wr, data_wr, cfg_wr, status_rd;
  logic        start_req, busy_any;
  logic        start_q, done_q, pinflip_q;
  logic [3:0]  pid_q;
  logic [31:0] status_word;

  // No wait states, every transfer ends in its access phase
  assign pready_o = 1'b1;
  assign access   = psel_i && penable_i;
  assign wr       = access && pwrite_i;

  assign mapped    = paddr_i inside {AddrCtrl, AddrData, AddrCfg, AddrStatus};
  assign ctrl_wr   = wr && (paddr_i == AddrCtrl);
  assign data_wr   = wr && (paddr_i == AddrData);
  assign cfg_wr    = wr && (paddr_i == AddrCfg);
  assign status_rd = access && !pwrite_i && (paddr_i == AddrStatus);

  // A start pulse already in flight counts as busy
  assign busy_any  = busy_i || start_q;
  assign start_req = ctrl_wr && pwdata_i[8];

  assign pslverr_o = access && (!mapped || (data_wr && fifo_wr.full) ||
                                (start_req && busy_any));

  // Payload bytes go straight into the FIFO at the end of the access phase
  assign fifo_wr.push_en   = data_wr && !fifo_wr.full;
  assign fifo_wr.push_data = pwdata_i[7:0];

  always_comb begin
    status_word                = '0;
    status_word[0]             = busy_any;
    status_word[1]             = done_q;
    status_word[2]             = fifo_wr.full;
    status_word[8 +: CntW]     = fifo_wr.count;
  end

  always_comb begin
    unique case (paddr_i)
      AddrCtrl:   prdata_o = {28'b0, pid_q};
      AddrCfg:    prdata_o = {31'b0, pinflip_q};
      AddrStatus: prdata_o = status_word;
      default:    prdata_o = '0;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      start_q   <= 1'b0;
      done_q    <= 1'b0;
      pinflip_q <= 1'b0;
      pid_q     <= '0;
    end else begin
      start_q <= start_req && !busy_any;
      if (ctrl_wr && !(start_req && busy_any)) begin
        pid_q <= pwdata_i[3:0];
      end
      if (cfg_wr) begin
        pinflip_q <= pwdata_i[0];
      end
      // Sticky done, a new packet end wins over the clearing read
      if (pkt_end_i) begin
        done_q <= 1'b1;
      end else if (status_rd) begin
        done_q <= 1'b0;
      end
    end
  end

  assign pkt_start_o = start_q;
  assign pid_o       = pid_q;
  assign pinflip_o   = pinflip_q;

endmodule

// ==== src/usb_tx_fifo.sv ====
/*
 * Synchronous byte FIFO
 * Circular buffer with a head entry visible without delay
 */
module usb_tx_fifo #(
  parameter int Depth = usb_tx_pkg::FifoDepthDefault
) (
  input  logic              clk_i,
  input  logic              rst_ni,
  usb_tx_fifo_if.buffer_wr  fifo_wr,
  usb_tx_fifo_if.buffer_rd  fifo_rd
);

  localparam int AddrW = $clog2(Depth);
  localparam int CntW  = AddrW + 1;

  logic [7:0]       mem_q [Depth];
  logic [AddrW-1:0] wr_ptr_q, rd_ptr_q;
  logic [CntW-1:0]  count_q;
  logic             push, pop;

  function automatic logic [AddrW-1:0] ptr_next(input logic [AddrW-1:0] ptr);
    return (ptr == AddrW'(Depth - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign push = fifo_wr.push_en && !fifo_wr.full;
  assign pop  = fifo_rd.pop_en && !fifo_rd.empty;

  assign fifo_wr.full     = (count_q == CntW'(Depth));
  assign fifo_wr.count    = count_q;
  assign fifo_rd.empty    = (count_q == '0);
  assign fifo_rd.pop_data = mem_q[rd_ptr_q];

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= fifo_wr.push_data;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) wr_ptr_q <= ptr_next(wr_ptr_q);
      if (pop)  rd_ptr_q <= ptr_next(rd_ptr_q);
      // Simultaneous push and pop leave the count unchanged
      if (push && !pop) begin
        count_q <= count_q + 1'b1;
      end else if (pop && !push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

endmodule

// ==== src/usb_tx_fifo_if.sv ====
/*
 * Byte FIFO interface
 * Push side for the register block, pop side for the transmitter
 */
interface usb_tx_fifo_if #(
  parameter int Depth = usb_tx_pkg::FifoDepthDefault
);

  localparam int CntW = $clog2(Depth) + 1;

  // Push side
  logic [7:0]      push_data;
  logic            push_en;
  logic            full;
  logic [CntW-1:0] count;

  // Pop side, pop_data is the head entry
  logic [7:0]      pop_data;
  logic            pop_en;
  logic            empty;

  modport writer    (output push_en, push_data, input full, count);
  modport buffer_wr (input push_en, push_data, output full, count);
  modport buffer_rd (input pop_en, output pop_data, empty);
  modport reader    (output pop_en, input pop_data, empty);

endinterface

// ==== src/usb_tx_pkg.sv ====
/*
 * USB full-speed transmitter package
 * Register offsets, PID codes, CRC16 constants and line states
 */
package usb_tx_pkg;

  //////////////////////////////
  // APB register map
  //////////////////////////////
  localparam logic [7:0] AddrCtrl   = 8'h00;
  localparam logic [7:0] AddrData   = 8'h04;
  localparam logic [7:0] AddrCfg    = 8'h08;
  localparam logic [7:0] AddrStatus = 8'h0C;

  // Default build parameters
  localparam int FifoDepthDefault = 16;
  localparam int ClkPerBitDefault = 4;

  // CRC16 over the data payload
  localparam logic [15:0] Crc16Init = 16'hFFFF;
  localparam logic [15:0] Crc16Poly = 16'h8005;

  //////////////////////////////
  // Packet identifiers
  //////////////////////////////
  // Data PIDs end in 2'b11
  localparam logic [3:0] PidData0 = 4'b0011;
  localparam logic [3:0] PidData1 = 4'b1011;
  localparam logic [3:0] PidAck   = 4'b0010;
  localparam logic [3:0] PidNak   = 4'b1010;

  // Line states as {D+, D-} before pin flip
  localparam logic [1:0] LineJ   = 2'b10;
  localparam logic [1:0] LineK   = 2'b01;
  localparam logic [1:0] LineSe0 = 2'b00;

endpackage

// ==== src/usb_tx_top.sv ====
/*
 * USB full-speed transmitter top level
 * APB register block, byte FIFO and line serializer
 */
module usb_tx_top #(
  parameter int FifoDepth = usb_tx_pkg::FifoDepthDefault,
  parameter int ClkPerBit = usb_tx_pkg::ClkPerBitDefault
) (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic [7:0]  paddr_i,
  input  logic        psel_i,
  input  logic        penable_i,
  input  logic        pwrite_i,
  input  logic [31:0] pwdata_i,
  output logic [31:0] prdata_o,
  output logic        pready_o,
  output logic        pslverr_o,
  output logic        usb_dp_o,
  output logic        usb_dn_o,
  output logic        usb_oe_o
);

  logic       pkt_start, pkt_end, busy, pinflip;
  logic [3:0] pid;

  usb_tx_fifo_if #(.Depth(FifoDepth)) fifo_if ();

  usb_tx_apb_regs #(.FifoDepth(FifoDepth)) u_regs (
    .clk_i, .rst_ni,
    .paddr_i, .psel_i, .penable_i, .pwrite_i, .pwdata_i,
    .prdata_o, .pready_o, .pslverr_o,
    .fifo_wr     (fifo_if.writer),
    .busy_i      (busy),
    .pkt_end_i   (pkt_end),
    .pkt_start_o (pkt_start),
    .pid_o       (pid),
    .pinflip_o   (pinflip)
  );

  usb_tx_fifo #(.Depth(FifoDepth)) u_fifo (
    .clk_i, .rst_ni,
    .fifo_wr (fifo_if.buffer_wr),
    .fifo_rd (fifo_if.buffer_rd)
  );

  usb_fs_tx #(.ClkPerBit(ClkPerBit)) u_tx (
    .clk_i, .rst_ni,
    .pkt_start_i (pkt_start),
    .pid_i       (pid),
    .pinflip_i   (pinflip),
    .fifo_rd     (fifo_if.reader),
    .busy_o      (busy),
    .pkt_end_o   (pkt_end),
    .usb_dp_o, .usb_dn_o, .usb_oe_o
  );

endmodule

// ==== usb_tx.f ====
src/usb_tx_pkg.sv
src/usb_tx_fifo_if.sv
src/usb_tx_apb_regs.sv
src/usb_tx_fifo.sv
src/usb_fs_tx.sv
src/usb_tx_top.sv
sim/usb_tx_sva.sv
sim/usb_tx_tb.sv
